/* sim/memStage_stim.txt */
# op1 sz1 vaddr1 sdata1 exc1 op0 sz0 vaddr0 sdata0 exc0
# expLd1 expLd0 excValid excLane excCode badVaddr nAcc addr1 strb1 addr0 strb0
2 2 00001000 cafef00d 0 2 1 00001006 00001234 0 0 0 0 0 0 0 2 00001000 f 00001006 c
2 0 80002003 000000ab 0 2 0 a0002001 0000005c 0 0 0 0 0 0 0 2 00002003 8 00002001 2
1 2 80001000 0 0 1 1 00001006 0 0 cafef00d 00001234 0 0 0 0 2 00001000 0 00001006 0
1 0 a0002003 0 0 1 0 00002001 0 0 000000ab 0000005c 0 0 0 0 2 00002003 0 00002001 0
1 1 00002000 0 0 1 0 00002002 0 0 00005c00 00000000 0 0 0 0 2 00002000 0 00002002 0
1 2 c0000010 0 0 1 2 40000020 0 0 30000004 10000008 0 0 0 0 2 c0000010 0 40000020 0
1 2 00003001 0 0 2 2 00003000 deadbeef 0 0 0 1 1 2 00003001 0 0 0 0 0
2 1 80003003 00005555 0 1 2 00003000 0 0 0 0 1 1 3 80003003 0 0 0 0 0
1 2 00003000 0 0 1 1 00003005 0 0 00000c00 0 1 0 2 00003005 1 00003000 0 0 0
2 0 00004002 00000077 0 2 2 00004001 12345678 1 0 0 1 0 1 00004001 1 00004002 4 0 0
1 2 00005002 0 1 1 2 00005000 0 0 0 0 1 1 1 00005002 0 0 0 0 0
1 2 00004000 0 0 1 1 00004002 0 0 00771000 00000077 0 0 0 0 2 00004000 0 00004002 0
0 0 00000000 0 0 0 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0
2 2 00006000 11223344 0 1 2 00006000 0 0 0 11223344 0 0 0 0 2 00006000 f 00006000 0
1 0 00006001 0 0 1 1 00006002 0 0 00000033 00001122 0 0 0 0 2 00006001 0 00006002 0

/* files.f */
+incdir+hw
hw/memStagePkg.sv
hw/memLane.sv
hw/laneCombiner.sv
hw/memStage.sv
sim/memStage_sva.sv
sim/memStageChecker.sv
sim/memStageTb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/memStagePkg.sv
      - hw/memLane.sv
      - hw/laneCombiner.sv
      - hw/memStage.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/memStage_sva.sv
      - sim/memStageChecker.sv
      - sim/memStageTb.sv

/* sim/memStageTb.sv */
`include "memStage_params.svh"

module memStageTb;

    logic clk = 1'b0;
    logic rstN;
    logic inValid;
    logic inReady;
    memStagePkg::memOp_e op1, op0;
    memStagePkg::memSize_e size1, size0;
    logic [`MEM_ADDR_WIDTH-1:0] vaddr1, vaddr0, badVaddr, awaddr, araddr;
    logic [`MEM_DATA_WIDTH-1:0] storeData1, storeData0, loadData1, loadData0;
    logic [`MEM_DATA_WIDTH-1:0] wdata, rdata;
    logic excIn1, excIn0, outValid, excValid, excLane;
    memStagePkg::excCode_e excCode;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;

    // expected values of the running test
    logic [31:0] expLoad1, expLoad0, expBadVaddr, expAddr0, expAddr1;
    logic [3:0] expStrb0, expStrb1;
    logic [1:0] expExcCode;
    logic expExcValid, expExcLane;
    int expAccCount, testId, errCount, testCount;

    // memory model state
    logic [31:0] mem [logic [31:0]];
    int awCnt, wCnt, arCnt, bCnt, rCnt;
    logic awGot, wGot, arGot;

    // stimulus parsing
    int fd, waitCycles;
    logic hung;
    string line;
    logic [31:0] f [0:20];

    always #4 clk = ~clk;

    memStage UUT (.*);

    memStageChecker outputCheck (.*);

    // unwritten words hold their own word index
    function automatic logic [31:0] readWord(logic [31:0] idx);
        return mem.exists(idx) ? mem[idx] : idx;
    endfunction

    always @(posedge clk or negedge rstN) begin
        logic [31:0] word;
        if (!rstN) begin
            awready <= 1'b0;
            wready <= 1'b0;
            arready <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            rdata <= '0;
            {awGot, wGot, arGot} <= 3'b000;
            {awCnt, wCnt, arCnt, bCnt, rCnt} <= '0;
        end else begin
            awready <= awvalid && !awready && (awCnt == 0);
            wready <= wvalid && !wready && (wCnt == 0);
            arready <= arvalid && !arready && (arCnt == 0);
            if (awvalid && !awready && awCnt != 0) awCnt <= awCnt - 1;
            if (wvalid && !wready && wCnt != 0) wCnt <= wCnt - 1;
            if (arvalid && !arready && arCnt != 0) arCnt <= arCnt - 1;
            if (awvalid && awready) begin
                awGot <= 1'b1;
                awCnt <= $urandom % 4;
            end
            if (wvalid && wready) begin
                wGot <= 1'b1;
                wCnt <= $urandom % 4;
                word = readWord(awaddr >> 2);
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) word[8*b +: 8] = wdata[8*b +: 8];
                end
                mem[awaddr >> 2] = word;
            end
            if (arvalid && arready) begin
                arGot <= 1'b1;
                arCnt <= $urandom % 4;
                rdata <= readWord(araddr >> 2);
            end
            // write response once both address and data are in
            if (awGot && wGot && !bvalid) begin
                if (bCnt == 0) bvalid <= 1'b1;
                else bCnt <= bCnt - 1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                {awGot, wGot} <= 2'b00;
                bCnt <= $urandom % 4;
            end
            if (arGot && !rvalid) begin
                if (rCnt == 0) rvalid <= 1'b1;
                else rCnt <= rCnt - 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                arGot <= 1'b0;
                rCnt <= $urandom % 4;
            end
        end
    end

    initial begin
        void'($urandom(32'h83ca_aeb9));
        rstN = 1'b0;
        inValid = 1'b0;
        op1 = memStagePkg::opNone;
        op0 = memStagePkg::opNone;
        size1 = memStagePkg::size1;
        size0 = memStagePkg::size1;
        {vaddr1, vaddr0, storeData1, storeData0} = '0;
        {excIn1, excIn0} = 2'b00;
        {bresp, rresp} = 4'b0000;
        {awready, wready, arready, bvalid, rvalid} = 5'b00000;
        rdata = '0;
        {expLoad1, expLoad0, expBadVaddr, expAddr0, expAddr1} = '0;
        {expStrb0, expStrb1, expExcCode, expExcValid, expExcLane} = '0;
        expAccCount = 0;
        testId = 0;
        hung = 1'b0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        fd = $fopen("sim/memStage_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file could not be opened");
            hung = 1'b1;
        end
        while (!hung && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]));
            @(posedge clk);
            testId <= testId + 1;
            inValid <= 1'b1;
            op1 <= memStagePkg::memOp_e'(f[0][1:0]);
            size1 <= memStagePkg::memSize_e'(f[1][1:0]);
            vaddr1 <= f[2];
            storeData1 <= f[3];
            excIn1 <= f[4][0];
            op0 <= memStagePkg::memOp_e'(f[5][1:0]);
            size0 <= memStagePkg::memSize_e'(f[6][1:0]);
            vaddr0 <= f[7];
            storeData0 <= f[8];
            excIn0 <= f[9][0];
            expLoad1 <= f[10];
            expLoad0 <= f[11];
            expExcValid <= f[12][0];
            expExcLane <= f[13][0];
            expExcCode <= f[14][1:0];
            expBadVaddr <= f[15];
            expAccCount <= f[16];
            expAddr1 <= f[17];
            expStrb1 <= f[18][3:0];
            expAddr0 <= f[19];
            expStrb0 <= f[20][3:0];
            waitCycles = 0;
            @(negedge clk);
            while (!inReady && waitCycles < 200) begin
                @(negedge clk);
                waitCycles++;
            end
            if (!inReady) begin
                $display("inReady never came back high");
                hung = 1'b1;
            end else begin
                @(posedge clk);
                inValid <= 1'b0;
                // lane inputs stay put until outValid
                waitCycles = 0;
                @(negedge clk);
                while (!outValid && waitCycles < 200) begin
                    @(negedge clk);
                    waitCycles++;
                end
                if (!outValid) begin
                    $display("outValid never arrived");
                    hung = 1'b1;
                end
            end
        end
        @(posedge clk);
        $display("tests %0d, errors %0d", testCount, errCount);
        if (hung || errCount != 0 || testCount == 0 ||
                UUT.combinerUnit.combinerSva.failCount != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

/* sim/memStageChecker.sv */
`include "memStage_params.svh"

module memStageChecker (
    input  logic        clk,
    input  logic        inValid,
    input  logic        inReady,
    input  logic        outValid,
    input  logic [31:0] loadData1,
    input  logic [31:0] loadData0,
    input  logic        excValid,
    input  logic        excLane,
    input  logic [1:0]  excCode,
    input  logic [31:0] badVaddr,
    input  logic        awvalid,
    input  logic        awready,
    input  logic [31:0] awaddr,
    input  logic [3:0]  wstrb,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [31:0] araddr,
    input  int          testId,
    input  logic [31:0] expLoad1,
    input  logic [31:0] expLoad0,
    input  logic        expExcValid,
    input  logic        expExcLane,
    input  logic [1:0]  expExcCode,
    input  logic [31:0] expBadVaddr,
    input  int          expAccCount,
    input  logic [31:0] expAddr1,
    input  logic [3:0]  expStrb1,
    input  logic [31:0] expAddr0,
    input  logic [3:0]  expStrb0,
    output int          errCount,
    output int          testCount
);

    logic [31:0] addrSeen [0:3];
    logic [3:0] strbSeen [0:3];
    int accCount, testErrs;
    logic busy = 1'b0;

    initial begin
        errCount = 0;
        testCount = 0;
        testErrs = 0;
        accCount = 0;
    end

    task automatic compareField(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %0t: test %0d %s got %h expected %h", $time, testId, what, got, exp);
            testErrs++;
        end
    endtask

    // AXI traffic, reads are logged with a zero strobe
    always @(posedge clk) begin
        if (inValid && inReady) begin
            accCount = 0;
            busy <= 1'b1;
        end
        if (outValid) busy <= 1'b0;
        if (awvalid && awready && accCount < 4) begin
            addrSeen[accCount] = awaddr;
            strbSeen[accCount] = wstrb;
            accCount++;
        end
        if (arvalid && arready && accCount < 4) begin
            addrSeen[accCount] = araddr;
            strbSeen[accCount] = 4'b0000;
            accCount++;
        end
    end

    always @(negedge clk) begin
        if (busy && !outValid && inReady) begin
            $display("Fail %0t: test %0d inReady high while busy", $time, testId);
            testErrs++;
        end
        if (outValid) begin
            compareField("loadData1", loadData1, expLoad1);
            compareField("loadData0", loadData0, expLoad0);
            compareField("excValid", excValid, expExcValid);
            if (expExcValid) begin
                compareField("excLane", excLane, expExcLane);
                compareField("excCode", excCode, expExcCode);
                compareField("badVaddr", badVaddr, expBadVaddr);
            end
            compareField("access count", accCount, expAccCount);
            if (accCount >= 1 && expAccCount >= 1) begin
                compareField("first address", addrSeen[0], expAddr1);
                compareField("first strobe", strbSeen[0], expStrb1);
            end
            if (accCount >= 2 && expAccCount >= 2) begin
                compareField("second address", addrSeen[1], expAddr0);
                compareField("second strobe", strbSeen[1], expStrb0);
            end
            $display("test %0d done, %0d mismatches", testId, testErrs);
            errCount += testErrs;
            testErrs = 0;
            testCount++;
        end
    end

endmodule

/* sim/memStage_sva.sv */
module memStageSva (
    input logic clk,
    input logic rstN,
    input logic inReady,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic arvalid,
    input logic arready,
    input logic bready,
    input logic rready,
    input logic outValid,
    input logic excValid
);

    int failCount = 0;

    // valid is held until its handshake
    awHeld: assert property (@(posedge clk) disable iff (!rstN)
        awvalid && !awready |=> awvalid) else begin
        $error("awvalid dropped early");
        failCount++;
    end
    wHeld: assert property (@(posedge clk) disable iff (!rstN)
        wvalid && !wready |=> wvalid) else begin
        $error("wvalid dropped early");
        failCount++;
    end
    arHeld: assert property (@(posedge clk) disable iff (!rstN)
        arvalid && !arready |=> arvalid) else begin
        $error("arvalid dropped early");
        failCount++;
    end

    outPulse: assert property (@(posedge clk) disable iff (!rstN)
        outValid |=> !outValid) else begin
        $error("outValid longer than one cycle");
        failCount++;
    end

    // idle right as reset is released
    resetQuiet: assert property (@(posedge clk) $rose(rstN) |->
        !awvalid && !wvalid && !arvalid && !bready && !rready && !outValid && !excValid
        && inReady) else begin
        $error("outputs not idle after reset");
        failCount++;
    end

endmodule

bind laneCombiner memStageSva combinerSva (.*);

/* hw/memStage.sv */
`include "memStage_params.svh"

module memStage (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           inValid,
    output logic                           inReady,
    input  memStagePkg::memOp_e            op1,
    input  memStagePkg::memSize_e          size1,
    input  logic [`MEM_ADDR_WIDTH-1:0]     vaddr1,
    input  logic [`MEM_DATA_WIDTH-1:0]     storeData1,
    input  logic                           excIn1,
    input  memStagePkg::memOp_e            op0,
    input  memStagePkg::memSize_e          size0,
    input  logic [`MEM_ADDR_WIDTH-1:0]     vaddr0,
    input  logic [`MEM_DATA_WIDTH-1:0]     storeData0,
    input  logic                           excIn0,
    output logic [`MEM_DATA_WIDTH-1:0]     loadData1,
    output logic [`MEM_DATA_WIDTH-1:0]     loadData0,
    output logic                           outValid,
    output logic                           excValid,
    output logic                           excLane,
    output memStagePkg::excCode_e          excCode,
    output logic [`MEM_ADDR_WIDTH-1:0]     badVaddr,
    output logic [`MEM_ADDR_WIDTH-1:0]     awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [`MEM_DATA_WIDTH-1:0]     wdata,
    output logic [3:0]                     wstrb,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready,
    output logic [`MEM_ADDR_WIDTH-1:0]     araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [`MEM_DATA_WIDTH-1:0]     rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rvalid,
    output logic                           rready
);

    logic                       lane1DoAccess, lane0DoAccess;
    logic                       lane1IsWrite, lane0IsWrite;
    logic [`MEM_ADDR_WIDTH-1:0] lane1Paddr, lane0Paddr;
    logic [`MEM_DATA_WIDTH-1:0] lane1Wdata, lane0Wdata;
    logic [`MEM_DATA_WIDTH-1:0] lane1Rdata, lane0Rdata;
    logic [3:0]                 lane1Strobe, lane0Strobe;
    memStagePkg::excCode_e      lane1Fault, lane0Fault;

    // older instruction, served first on the bus
    // lane inputs stay on the ports until outValid for load extraction
    memLane lane1Unit (
        .op(op1), .size(size1), .vaddr(vaddr1), .storeData(storeData1), .excIn(excIn1),
        .rdata(lane1Rdata), .doAccess(lane1DoAccess), .isWrite(lane1IsWrite),
        .paddr(lane1Paddr), .wdata(lane1Wdata), .strobe(lane1Strobe),
        .fault(lane1Fault), .loadData(loadData1)
    );

    memLane lane0Unit (
        .op(op0), .size(size0), .vaddr(vaddr0), .storeData(storeData0), .excIn(excIn0),
        .rdata(lane0Rdata), .doAccess(lane0DoAccess), .isWrite(lane0IsWrite),
        .paddr(lane0Paddr), .wdata(lane0Wdata), .strobe(lane0Strobe),
        .fault(lane0Fault), .loadData(loadData0)
    );

    laneCombiner combinerUnit (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
        .doAccess1(lane1DoAccess), .doAccess0(lane0DoAccess),
        .isWrite1(lane1IsWrite), .isWrite0(lane0IsWrite),
        .paddr1(lane1Paddr), .paddr0(lane0Paddr),
        .wdata1(lane1Wdata), .wdata0(lane0Wdata),
        .strobe1(lane1Strobe), .strobe0(lane0Strobe),
        .fault1(lane1Fault), .fault0(lane0Fault),
        .vaddr1(vaddr1), .vaddr0(vaddr0),
        .rdata1(lane1Rdata), .rdata0(lane0Rdata),
        .outValid(outValid), .excValid(excValid), .excLane(excLane),
        .excCode(excCode), .badVaddr(badVaddr),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

endmodule

/* hw/laneCombiner.sv */
`include "memStage_params.svh"

module laneCombiner (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           inValid,
    output logic                           inReady,
    input  logic                           doAccess1,
    input  logic                           doAccess0,
    input  logic                           isWrite1,
    input  logic                           isWrite0,
    input  logic [`MEM_ADDR_WIDTH-1:0]     paddr1,
    input  logic [`MEM_ADDR_WIDTH-1:0]     paddr0,
    input  logic [`MEM_DATA_WIDTH-1:0]     wdata1,
    input  logic [`MEM_DATA_WIDTH-1:0]     wdata0,
    input  logic [3:0]                     strobe1,
    input  logic [3:0]                     strobe0,
    input  memStagePkg::excCode_e          fault1,
    input  memStagePkg::excCode_e          fault0,
    input  logic [`MEM_ADDR_WIDTH-1:0]     vaddr1,
    input  logic [`MEM_ADDR_WIDTH-1:0]     vaddr0,
    output logic [`MEM_DATA_WIDTH-1:0]     rdata1,
    output logic [`MEM_DATA_WIDTH-1:0]     rdata0,
    output logic                           outValid,
    output logic                           excValid,
    output logic                           excLane,
    output memStagePkg::excCode_e          excCode,
    output logic [`MEM_ADDR_WIDTH-1:0]     badVaddr,
    output logic [`MEM_ADDR_WIDTH-1:0]     awaddr,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [`MEM_DATA_WIDTH-1:0]     wdata,
    output logic [3:0]                     wstrb,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic [1:0]                     bresp,
    input  logic                           bvalid,
    output logic                           bready,
    output logic [`MEM_ADDR_WIDTH-1:0]     araddr,
    output logic                           arvalid,
    input  logic                           arready,
    input  logic [`MEM_DATA_WIDTH-1:0]     rdata,
    input  logic [1:0]                     rresp,
    input  logic                           rvalid,
    output logic                           rready
);

    memStagePkg::busState_e     state, stateNext;
    logic                       accept;
    logic                       fault1Hit;
    logic                       inAccess;
    logic                       curWrite;
    logic                       respDone;
    logic                       startAccess;
    logic                       nextWrite;
    logic                       acc0Q, wr1Q, wr0Q;
    logic                       awvalidQ, wvalidQ, arvalidQ;
    logic                       excValidQ, excLaneQ;
    memStagePkg::excCode_e      excCodeQ;
    logic [`MEM_ADDR_WIDTH-1:0] paddr1Q, paddr0Q, badVaddrQ;
    logic [`MEM_DATA_WIDTH-1:0] wdata1Q, wdata0Q, rdata1Q, rdata0Q;
    logic [3:0]                 strobe1Q, strobe0Q;

    assign inReady = (state == memStagePkg::stIdle);
    assign accept = inReady && inValid;
    assign fault1Hit = (fault1 != memStagePkg::excNone);

    assign inAccess = (state == memStagePkg::stLane1) || (state == memStagePkg::stLane0);
    assign curWrite = (state == memStagePkg::stLane0) ? wr0Q : wr1Q;
    // bresp and rresp are not checked
    assign respDone = (bvalid && bready) || (rvalid && rready);

    always_comb begin
        stateNext = state;
        case (state)
            memStagePkg::stIdle: begin
                if (inValid) begin
                    if (doAccess1) begin
                        stateNext = memStagePkg::stLane1;
                    end else if (doAccess0 && !fault1Hit) begin
                        stateNext = memStagePkg::stLane0;
                    end else begin
                        stateNext = memStagePkg::stDone;
                    end
                end
            end
            memStagePkg::stLane1: begin
                if (respDone) begin
                    stateNext = acc0Q ? memStagePkg::stLane0 : memStagePkg::stDone;
                end
            end
            memStagePkg::stLane0: begin
                if (respDone) begin
                    stateNext = memStagePkg::stDone;
                end
            end
            default: begin
                stateNext = memStagePkg::stIdle;
            end
        endcase
    end

    // a new access starts whenever a lane state is entered
    assign startAccess = (stateNext != state) &&
                         ((stateNext == memStagePkg::stLane1) ||
                          (stateNext == memStagePkg::stLane0));
    assign nextWrite = (state == memStagePkg::stIdle) ?
                       ((stateNext == memStagePkg::stLane1) ? isWrite1 : isWrite0) : wr0Q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= memStagePkg::stIdle;
            acc0Q <= 1'b0;
            wr1Q <= 1'b0;
            wr0Q <= 1'b0;
            awvalidQ <= 1'b0;
            wvalidQ <= 1'b0;
            arvalidQ <= 1'b0;
            excValidQ <= 1'b0;
        end else begin
            state <= stateNext;
            if (accept) begin
                // older lane fault kills the younger access
                acc0Q <= doAccess0 && !fault1Hit;
                wr1Q <= isWrite1;
                wr0Q <= isWrite0;
                excValidQ <= fault1Hit || (fault0 != memStagePkg::excNone);
            end
            if (startAccess) begin
                awvalidQ <= nextWrite;
                wvalidQ <= nextWrite;
                arvalidQ <= !nextWrite;
            end else begin
                // each channel drops on its own handshake
                if (awready) begin
                    awvalidQ <= 1'b0;
                end
                if (wready) begin
                    wvalidQ <= 1'b0;
                end
                if (arready) begin
                    arvalidQ <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            paddr1Q <= paddr1;
            paddr0Q <= paddr0;
            wdata1Q <= wdata1;
            wdata0Q <= wdata0;
            strobe1Q <= strobe1;
            strobe0Q <= strobe0;
            rdata1Q <= '0;
            rdata0Q <= '0;
            excLaneQ <= fault1Hit;
            excCodeQ <= fault1Hit ? fault1 : fault0;
            badVaddrQ <= fault1Hit ? vaddr1 : vaddr0;
        end else if (rvalid && rready) begin
            if (state == memStagePkg::stLane1) begin
                rdata1Q <= rdata;
            end else begin
                rdata0Q <= rdata;
            end
        end
    end

    // bus request follows the lane being served
    assign awaddr = (state == memStagePkg::stLane0) ? paddr0Q : paddr1Q;
    assign araddr = awaddr;
    assign wdata = (state == memStagePkg::stLane0) ? wdata0Q : wdata1Q;
    assign wstrb = (state == memStagePkg::stLane0) ? strobe0Q : strobe1Q;
    assign awvalid = awvalidQ;
    assign wvalid = wvalidQ;
    assign arvalid = arvalidQ;
    assign bready = inAccess && curWrite && !awvalidQ && !wvalidQ;
    assign rready = inAccess && !curWrite && !arvalidQ;

    assign outValid = (state == memStagePkg::stDone);
    assign excValid = outValid && excValidQ;
    assign excLane = excLaneQ;
    assign excCode = excCodeQ;
    assign badVaddr = badVaddrQ;
    assign rdata1 = rdata1Q;
    assign rdata0 = rdata0Q;

endmodule

/* hw/memLane.sv */
`include "memStage_params.svh"

module memLane (
    input  memStagePkg::memOp_e            op,
    input  memStagePkg::memSize_e          size,
    input  logic [`MEM_ADDR_WIDTH-1:0]     vaddr,
    input  logic [`MEM_DATA_WIDTH-1:0]     storeData,
    input  logic                           excIn,
    input  logic [`MEM_DATA_WIDTH-1:0]     rdata,
    output logic                           doAccess,
    output logic                           isWrite,
    output logic [`MEM_ADDR_WIDTH-1:0]     paddr,
    output logic [`MEM_DATA_WIDTH-1:0]     wdata,
    output logic [3:0]                     strobe,
    output memStagePkg::excCode_e          fault,
    output logic [`MEM_DATA_WIDTH-1:0]     loadData
);

    logic                       inKseg;
    logic [1:0]                 offset;
    logic                       misaligned;
    logic                       isLoad;
    logic [`MEM_DATA_WIDTH-1:0] shifted;

    assign offset = vaddr[1:0];
    assign isLoad = (op == memStagePkg::opLoad);
    assign isWrite = (op == memStagePkg::opStore);

    // kseg0 and kseg1 are direct mapped
    assign inKseg = (vaddr >= `KSEG_BASE) && (vaddr <= `KSEG_END);
    assign paddr = inKseg ? {3'b000, vaddr[`MEM_ADDR_WIDTH-4:0]} : vaddr;

    // store data replicated so every byte lane sees it
    always_comb begin
        wdata = storeData;
        strobe = 4'b0000;
        misaligned = 1'b0;
        case (size)
            memStagePkg::size1: begin
                wdata = {4{storeData[7:0]}};
                strobe = 4'b0001 << offset;
            end
            memStagePkg::size2: begin
                wdata = {2{storeData[15:0]}};
                strobe = offset[1] ? 4'b1100 : 4'b0011;
                misaligned = offset[0];
            end
            memStagePkg::size4: begin
                wdata = storeData;
                strobe = 4'b1111;
                misaligned = (offset != 2'b00);
            end
            default: begin
                wdata = storeData;
                strobe = 4'b0000;
                misaligned = 1'b0;
            end
        endcase
    end

    // pending exception wins over address errors
    always_comb begin
        fault = memStagePkg::excNone;
        if (excIn) begin
            fault = memStagePkg::excPending;
        end else if (misaligned && isLoad) begin
            fault = memStagePkg::excAdel;
        end else if (misaligned && isWrite) begin
            fault = memStagePkg::excAdes;
        end
    end

    assign doAccess = (isLoad || isWrite) && (fault == memStagePkg::excNone);

    // bring the addressed bytes down to bit 0
    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        case (size)
            memStagePkg::size1: begin
                loadData = {{(`MEM_DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            end
            memStagePkg::size2: begin
                loadData = {{(`MEM_DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            end
            memStagePkg::size4: begin
                loadData = shifted;
            end
            default: begin
                loadData = '0;
            end
        endcase
    end

endmodule

/* hw/memStagePkg.sv */
package memStagePkg;

    // operation carried by one lane
    typedef enum logic [1:0] {
        opNone  = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2
    } memOp_e;

    // access width in bytes
    typedef enum logic [1:0] {
        size1 = 2'd0,
        size2 = 2'd1,
        size4 = 2'd2
    } memSize_e;

    // exception kind reported by a lane
    // excPending comes from an earlier stage
    typedef enum logic [1:0] {
        excNone    = 2'd0,
        excPending = 2'd1,
        excAdel    = 2'd2,
        excAdes    = 2'd3
    } excCode_e;

    // bus sequencer in the combiner
    // lane 1 is always served before lane 0
    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stLane1 = 2'd1,
        stLane0 = 2'd2,
        stDone  = 2'd3
    } busState_e;

endpackage

/* hw/memStage_params.svh */
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// datapath widths of the memory stage
`define MEM_DATA_WIDTH 32
`define MEM_ADDR_WIDTH 32

// unmapped kernel window, kseg0 followed by kseg1
// addresses inside lose their top three bits
`define KSEG_BASE 32'h8000_0000
`define KSEG_END  32'hBFFF_FFFF

`endif
